//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

	//////////////////////////////
	// Machine sizes

	localparam int data_w     = 32;
	localparam int reg_count  = 32;
	localparam int reg_addr_w = 5;

	//////////////////////////////
	// Instruction field layout

	localparam int opcode_w  = 6;
	localparam int funct_w   = 6;
	localparam int shamt_w   = 5;
	localparam int imm_w     = 16;
	localparam int target_w  = 26;

	// Low bit of each field inside the instruction word
	localparam int rs_lsb    = 21;
	localparam int rt_lsb    = 16;
	localparam int rd_lsb    = 11;
	localparam int shamt_lsb = 6;

	//////////////////////////////
	// Primary opcodes

	typedef enum logic [opcode_w-1:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,
		op_slti  = 6'h0a,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// Function codes for R-type
	typedef enum logic [funct_w-1:0] {
		fn_sll = 6'h00,
		fn_srl = 6'h02,
		fn_jr  = 6'h08,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_xor = 6'h26,
		fn_slt = 6'h2a
	} funct_e;

endpackage

`default_nettype wire

//--- ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	//////////////////////////////
	// ALU operation select

	// Consumed by the execute stage
	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_xor = 4'd4,
		alu_slt = 4'd5,
		alu_sll = 4'd6,
		alu_srl = 4'd7,
		alu_lui = 4'd8,
		alu_nop = 4'd9
	} alu_op_e;

	//////////////////////////////
	// Immediate extension

	// Logical immediates take zero fill, everything else sign fill
	typedef enum logic {
		ext_sign = 1'b0,
		ext_zero = 1'b1
	} ext_mode_e;

endpackage

`default_nettype wire

//--- control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit
	import isa_pkg::*, ctrl_pkg::*;
(
	input  opcode_e   opcode,
	input  funct_e    funct,
	output alu_op_e   alu_op,
	output ext_mode_e ext_mode,
	output logic      alu_src,
	output logic      reg_dst,
	output logic      branch,
	output logic      branch_ne,
	output logic      jump,
	output logic      jump_reg,
	output logic      link,
	output logic      mem_read,
	output logic      mem_write,
	output logic      mem_to_reg,
	output logic      reg_write,
	output logic      illegal
);

	always_comb
	begin
		// All controls idle unless an encoding below claims them
		alu_op     = alu_nop;
		ext_mode   = ext_sign;
		alu_src    = 1'b0;
		reg_dst    = 1'b0;
		branch     = 1'b0;
		branch_ne  = 1'b0;
		jump       = 1'b0;
		jump_reg   = 1'b0;
		link       = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_to_reg = 1'b0;
		reg_write  = 1'b0;
		illegal    = 1'b0;

		case (opcode)
			//////////////////////////////
			// Register to register
			op_rtype:
			begin
				reg_dst   = 1'b1;
				reg_write = 1'b1;
				case (funct)
					fn_add: alu_op = alu_add;
					fn_sub: alu_op = alu_sub;
					fn_and: alu_op = alu_and;
					fn_or:  alu_op = alu_or;
					fn_xor: alu_op = alu_xor;
					fn_slt: alu_op = alu_slt;
					fn_sll: alu_op = alu_sll;
					fn_srl: alu_op = alu_srl;
					fn_jr:
					begin
						// Jump through rs, no result to write
						reg_dst   = 1'b0;
						reg_write = 1'b0;
						jump_reg  = 1'b1;
					end
					default:
					begin
						reg_dst   = 1'b0;
						reg_write = 1'b0;
						illegal   = 1'b1;
					end
				endcase
			end

			//////////////////////////////
			// Immediate arithmetic and logic
			op_addi, op_slti:
			begin
				alu_op    = (opcode == op_addi) ? alu_add : alu_slt;
				alu_src   = 1'b1;
				reg_write = 1'b1;
			end
			op_andi, op_ori:
			begin
				alu_op    = (opcode == op_andi) ? alu_and : alu_or;
				ext_mode  = ext_zero;
				alu_src   = 1'b1;
				reg_write = 1'b1;
			end
			op_lui:
			begin
				alu_op    = alu_lui;
				alu_src   = 1'b1;
				reg_write = 1'b1;
			end

			// Loads and stores, address is rs plus offset
			op_lw:
			begin
				alu_op     = alu_add;
				alu_src    = 1'b1;
				mem_read   = 1'b1;
				mem_to_reg = 1'b1;
				reg_write  = 1'b1;
			end
			op_sw:
			begin
				alu_op    = alu_add;
				alu_src   = 1'b1;
				mem_write = 1'b1;
			end

			//////////////////////////////
			// Control flow
			op_beq, op_bne:
			begin
				// Compare by subtraction in execute
				alu_op    = alu_sub;
				branch    = 1'b1;
				branch_ne = (opcode == op_bne);
			end
			op_j:
			begin
				jump = 1'b1;
			end
			op_jal:
			begin
				jump      = 1'b1;
				link      = 1'b1;
				reg_write = 1'b1;
			end

			default:
			begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
	import isa_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [reg_addr_w-1:0] rs_addr,
	input  logic [reg_addr_w-1:0] rt_addr,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic                  reg_write,
	input  logic [data_w-1:0]     wr_data,
	output logic [data_w-1:0]     rs_data,
	output logic [data_w-1:0]     rt_data
);

	logic [data_w-1:0] regs [reg_count];

	logic wr_en;
	logic rs_zero;
	logic rt_zero;
	logic rs_bypass;
	logic rt_bypass;

	// Register zero is hardwired, never stored
	assign wr_en = reg_write && (wr_addr != '0);

	//////////////////////////////
	// Write port

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////
	// Read ports

	assign rs_zero = (rs_addr == '0);
	assign rt_zero = (rt_addr == '0);

	// Same-cycle write-back wins over the stored word
	assign rs_bypass = wr_en && (wr_addr == rs_addr);
	assign rt_bypass = wr_en && (wr_addr == rt_addr);

	assign rs_data = rs_zero   ? '0 :
	                 rs_bypass ? wr_data :
	                             regs[rs_addr];

	assign rt_data = rt_zero   ? '0 :
	                 rt_bypass ? wr_data :
	                             regs[rt_addr];

endmodule

`default_nettype wire

//--- id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage
	import isa_pkg::*, ctrl_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	// From fetch
	input  logic                  in_valid,
	input  logic [data_w-1:0]     instr,
	input  logic [data_w-1:0]     pc_plus4,

	// From write-back
	input  logic                  reg_write,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic [data_w-1:0]     wr_data,

	// ID/EX register
	output logic                  out_valid,
	output logic [data_w-1:0]     rs_data,
	output logic [data_w-1:0]     rt_data,
	output logic [data_w-1:0]     imm_ext,
	output logic [reg_addr_w-1:0] rt_addr,
	output logic [reg_addr_w-1:0] rd_addr,
	output logic [shamt_w-1:0]    shamt,
	output logic [data_w-1:0]     branch_target,
	output logic [data_w-1:0]     jump_target,
	output logic [data_w-1:0]     pc_plus4_out,
	output alu_op_e               alu_op,
	output logic                  alu_src,
	output logic                  reg_dst,
	output logic                  branch,
	output logic                  branch_ne,
	output logic                  jump,
	output logic                  jump_reg,
	output logic                  link,
	output logic                  mem_read,
	output logic                  mem_write,
	output logic                  mem_to_reg,
	output logic                  reg_write_out,
	output logic                  illegal
);

	//////////////////////////////
	// Instruction fields

	opcode_e               f_opcode;
	funct_e                f_funct;
	logic [reg_addr_w-1:0] f_rs;
	logic [reg_addr_w-1:0] f_rt;
	logic [reg_addr_w-1:0] f_rd;
	logic [shamt_w-1:0]    f_shamt;
	logic [imm_w-1:0]      f_imm16;
	logic [target_w-1:0]   f_target26;

	assign f_opcode   = opcode_e'(instr[data_w-1 -: opcode_w]);
	assign f_funct    = funct_e'(instr[funct_w-1:0]);
	assign f_rs       = instr[rs_lsb +: reg_addr_w];
	assign f_rt       = instr[rt_lsb +: reg_addr_w];
	assign f_rd       = instr[rd_lsb +: reg_addr_w];
	assign f_shamt    = instr[shamt_lsb +: shamt_w];
	assign f_imm16    = instr[imm_w-1:0];
	assign f_target26 = instr[target_w-1:0];

	// Decoded controls, before the pipeline register
	alu_op_e   dec_alu_op;
	ext_mode_e dec_ext_mode;
	logic      dec_alu_src;
	logic      dec_reg_dst;
	logic      dec_branch;
	logic      dec_branch_ne;
	logic      dec_jump;
	logic      dec_jump_reg;
	logic      dec_link;
	logic      dec_mem_read;
	logic      dec_mem_write;
	logic      dec_mem_to_reg;
	logic      dec_reg_write;
	logic      dec_illegal;

	control_unit i_control_unit (
		.opcode     (f_opcode),
		.funct      (f_funct),
		.alu_op     (dec_alu_op),
		.ext_mode   (dec_ext_mode),
		.alu_src    (dec_alu_src),
		.reg_dst    (dec_reg_dst),
		.branch     (dec_branch),
		.branch_ne  (dec_branch_ne),
		.jump       (dec_jump),
		.jump_reg   (dec_jump_reg),
		.link       (dec_link),
		.mem_read   (dec_mem_read),
		.mem_write  (dec_mem_write),
		.mem_to_reg (dec_mem_to_reg),
		.reg_write  (dec_reg_write),
		.illegal    (dec_illegal)
	);

	logic [data_w-1:0] rf_rs_data;
	logic [data_w-1:0] rf_rt_data;

	register_file i_register_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rs_addr   (f_rs),
		.rt_addr   (f_rt),
		.wr_addr   (wr_addr),
		.reg_write (reg_write),
		.wr_data   (wr_data),
		.rs_data   (rf_rs_data),
		.rt_data   (rf_rt_data)
	);

	//////////////////////////////
	// Immediate and targets

	logic [data_w-1:0] imm_sext;
	logic [data_w-1:0] imm_zext;

	assign imm_sext = {{(data_w - imm_w){f_imm16[imm_w-1]}}, f_imm16};
	assign imm_zext = {{(data_w - imm_w){1'b0}}, f_imm16};

	// Link register is the top index
	logic [reg_addr_w-1:0] rd_sel;

	assign rd_sel = dec_link ? reg_addr_w'(reg_count - 1) : f_rd;

	//////////////////////////////
	// ID/EX register, controls

	// A bubble carries no side effects into execute
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid     <= 1'b0;
			alu_op        <= alu_nop;
			alu_src       <= 1'b0;
			reg_dst       <= 1'b0;
			branch        <= 1'b0;
			branch_ne     <= 1'b0;
			jump          <= 1'b0;
			jump_reg      <= 1'b0;
			link          <= 1'b0;
			mem_read      <= 1'b0;
			mem_write     <= 1'b0;
			mem_to_reg    <= 1'b0;
			reg_write_out <= 1'b0;
			illegal       <= 1'b0;
		end
		else
		begin
			out_valid     <= in_valid;
			alu_op        <= in_valid ? dec_alu_op : alu_nop;
			alu_src       <= in_valid & dec_alu_src;
			reg_dst       <= in_valid & dec_reg_dst;
			branch        <= in_valid & dec_branch;
			branch_ne     <= in_valid & dec_branch_ne;
			jump          <= in_valid & dec_jump;
			jump_reg      <= in_valid & dec_jump_reg;
			link          <= in_valid & dec_link;
			mem_read      <= in_valid & dec_mem_read;
			mem_write     <= in_valid & dec_mem_write;
			mem_to_reg    <= in_valid & dec_mem_to_reg;
			reg_write_out <= in_valid & dec_reg_write;
			illegal       <= in_valid & dec_illegal;
		end
	end

	// Payload side, loaded every edge
	always_ff @(posedge clk)
	begin
		rs_data       <= rf_rs_data;
		rt_data       <= rf_rt_data;
		imm_ext       <= (dec_ext_mode == ext_zero) ? imm_zext : imm_sext;
		rt_addr       <= f_rt;
		rd_addr       <= rd_sel;
		shamt         <= f_shamt;
		branch_target <= pc_plus4 + (imm_sext << 2);
		jump_target   <= {pc_plus4[data_w-1 -: 4], f_target26, 2'b00};
		pc_plus4_out  <= pc_plus4;
	end

endmodule

`default_nettype wire

//--- id_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_checker
	import isa_pkg::*, ctrl_pkg::*;
(
	input wire logic                  clk,
	input wire logic                  rst_n,
	input wire logic                  in_valid,
	input wire logic                  out_valid,
	input wire logic [data_w-1:0]     rs_data,
	input wire logic [data_w-1:0]     rt_data,
	input wire logic [data_w-1:0]     imm_ext,
	input wire logic [reg_addr_w-1:0] rt_addr,
	input wire logic [reg_addr_w-1:0] rd_addr,
	input wire logic [shamt_w-1:0]    shamt,
	input wire logic [data_w-1:0]     branch_target,
	input wire logic [data_w-1:0]     jump_target,
	input wire logic [data_w-1:0]     pc_plus4_out,
	input wire alu_op_e               alu_op,
	input wire logic                  alu_src,
	input wire logic                  reg_dst,
	input wire logic                  branch,
	input wire logic                  branch_ne,
	input wire logic                  jump,
	input wire logic                  jump_reg,
	input wire logic                  link,
	input wire logic                  mem_read,
	input wire logic                  mem_write,
	input wire logic                  mem_to_reg,
	input wire logic                  reg_write_out,
	input wire logic                  illegal
);

	int fail_count = 0;

	logic [15:0] ctrl_vec;
	logic [7:0]  bubble_vec;

	// Same bit order as the expected control word in the testbench
	assign ctrl_vec = {alu_op, alu_src, reg_dst, branch, branch_ne, jump, jump_reg, link,
		mem_read, mem_write, mem_to_reg, reg_write_out, illegal};

	// Controls that must never leave a bubble
	assign bubble_vec = {reg_write_out, mem_read, mem_write, branch, branch_ne, jump,
		jump_reg, illegal};

	//////////////////////////////
	// Expected values one cycle old

	logic              prev_valid;
	logic [15:0]       prev_ctrl;
	logic [data_w-1:0] prev_rs;
	logic [data_w-1:0] prev_rt;
	logic [data_w-1:0] prev_imm;
	logic [data_w-1:0] prev_bt;
	logic [data_w-1:0] prev_jt;
	logic [data_w-1:0] prev_pc;
	logic [4:0]        prev_rd;
	logic [4:0]        prev_rt_addr;
	logic [4:0]        prev_shamt;

	always_ff @(posedge clk)
	begin
		prev_valid   <= in_valid;
		prev_ctrl    <= tb_id_stage.exp_ctrl;
		prev_rs      <= tb_id_stage.exp_rs_data;
		prev_rt      <= tb_id_stage.exp_rt_data;
		prev_imm     <= tb_id_stage.exp_imm_ext;
		prev_bt      <= tb_id_stage.exp_branch_target;
		prev_jt      <= tb_id_stage.exp_jump_target;
		prev_pc      <= tb_id_stage.exp_pc_plus4;
		prev_rd      <= tb_id_stage.exp_rd_addr;
		prev_rt_addr <= tb_id_stage.exp_rt_addr;
		prev_shamt   <= tb_id_stage.exp_shamt;
	end

	//////////////////////////////
	// Reset and bubbles

	a_reset_valid:
		assert property (@(posedge clk) $rose(rst_n) |-> out_valid == 1'b0)
		else
		begin
			$error("error out_valid after reset exp 0 got %h", $sampled(out_valid));
			fail_count++;
		end

	a_reset_flags:
		assert property (@(posedge clk) $rose(rst_n) |-> ctrl_vec[11:0] == 12'h000)
		else
		begin
			$error("error control flags after reset exp 000 got %h", $sampled(ctrl_vec[11:0]));
			fail_count++;
		end

	a_latency:
		assert property (@(posedge clk) disable iff (!rst_n) out_valid == prev_valid)
		else
		begin
			$error("error out_valid exp %h got %h", $sampled(prev_valid), $sampled(out_valid));
			fail_count++;
		end

	a_bubble:
		assert property (@(posedge clk) disable iff (!rst_n) !prev_valid |-> bubble_vec == 8'h00)
		else
		begin
			$error("error bubble controls exp 00 got %h", $sampled(bubble_vec));
			fail_count++;
		end

	//////////////////////////////
	// Decoded payload

	a_controls:
		assert property (@(posedge clk) disable iff (!rst_n) prev_valid |-> ctrl_vec == prev_ctrl)
		else
		begin
			$error("error ctrl_vec exp %h got %h", $sampled(prev_ctrl), $sampled(ctrl_vec));
			fail_count++;
		end

	a_rs_data:
		assert property (@(posedge clk) disable iff (!rst_n) prev_valid |-> rs_data == prev_rs)
		else
		begin
			$error("error rs_data exp %h got %h", $sampled(prev_rs), $sampled(rs_data));
			fail_count++;
		end

	a_rt_data:
		assert property (@(posedge clk) disable iff (!rst_n) prev_valid |-> rt_data == prev_rt)
		else
		begin
			$error("error rt_data exp %h got %h", $sampled(prev_rt), $sampled(rt_data));
			fail_count++;
		end

	a_imm_ext:
		assert property (@(posedge clk) disable iff (!rst_n) prev_valid |-> imm_ext == prev_imm)
		else
		begin
			$error("error imm_ext exp %h got %h", $sampled(prev_imm), $sampled(imm_ext));
			fail_count++;
		end

	a_rt_addr:
		assert property (@(posedge clk) disable iff (!rst_n)
			prev_valid |-> rt_addr == prev_rt_addr)
		else
		begin
			$error("error rt_addr exp %h got %h", $sampled(prev_rt_addr), $sampled(rt_addr));
			fail_count++;
		end

	a_rd_addr:
		assert property (@(posedge clk) disable iff (!rst_n) prev_valid |-> rd_addr == prev_rd)
		else
		begin
			$error("error rd_addr exp %h got %h", $sampled(prev_rd), $sampled(rd_addr));
			fail_count++;
		end

	a_shamt:
		assert property (@(posedge clk) disable iff (!rst_n) prev_valid |-> shamt == prev_shamt)
		else
		begin
			$error("error shamt exp %h got %h", $sampled(prev_shamt), $sampled(shamt));
			fail_count++;
		end

	a_branch_target:
		assert property (@(posedge clk) disable iff (!rst_n)
			prev_valid |-> branch_target == prev_bt)
		else
		begin
			$error("error branch_target exp %h got %h", $sampled(prev_bt),
				$sampled(branch_target));
			fail_count++;
		end

	a_jump_target:
		assert property (@(posedge clk) disable iff (!rst_n)
			prev_valid |-> jump_target == prev_jt)
		else
		begin
			$error("error jump_target exp %h got %h", $sampled(prev_jt), $sampled(jump_target));
			fail_count++;
		end

	a_pc_plus4_out:
		assert property (@(posedge clk) disable iff (!rst_n)
			prev_valid |-> pc_plus4_out == prev_pc)
		else
		begin
			$error("error pc_plus4_out exp %h got %h", $sampled(prev_pc),
				$sampled(pc_plus4_out));
			fail_count++;
		end

endmodule

`default_nettype wire

//--- tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage
	import isa_pkg::*, ctrl_pkg::*;
;

	localparam int clk_period = 20;
	localparam int n_idle     = 60;
	localparam int n_regs     = 64;
	localparam int n_wt       = 32;
	localparam int n_imm      = 64;

	// Reset, each test's cycles and one closing idle cycle per test
	localparam int total_cycles = 16 + (n_idle + 1) + (2 * n_regs + 3) + (n_wt + 1) + 30
		+ (n_imm + 1);

	// Bit positions in the expected control word below the 4-bit ALU op
	localparam int b_alu_src    = 11;
	localparam int b_reg_dst    = 10;
	localparam int b_branch     = 9;
	localparam int b_branch_ne  = 8;
	localparam int b_jump       = 7;
	localparam int b_jump_reg   = 6;
	localparam int b_link       = 5;
	localparam int b_mem_read   = 4;
	localparam int b_mem_write  = 3;
	localparam int b_mem_to_reg = 2;
	localparam int b_reg_write  = 1;
	localparam int b_illegal    = 0;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [31:0] instr;
	logic [31:0] pc_plus4;
	logic reg_write;
	logic [4:0] wr_addr;
	logic [31:0] wr_data;

	logic out_valid;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] imm_ext;
	logic [4:0] rt_addr;
	logic [4:0] rd_addr;
	logic [4:0] shamt;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] pc_plus4_out;
	alu_op_e alu_op;
	logic alu_src;
	logic reg_dst;
	logic branch;
	logic branch_ne;
	logic jump;
	logic jump_reg;
	logic link;
	logic mem_read;
	logic mem_write;
	logic mem_to_reg;
	logic reg_write_out;
	logic illegal;

	// Read by the bound checker
	logic [15:0] exp_ctrl;
	logic [31:0] exp_rs_data;
	logic [31:0] exp_rt_data;
	logic [31:0] exp_imm_ext;
	logic [31:0] exp_branch_target;
	logic [31:0] exp_jump_target;
	logic [31:0] exp_pc_plus4;
	logic [4:0]  exp_rd_addr;
	logic [4:0]  exp_rt_addr;
	logic [4:0]  exp_shamt;

	logic [31:0] shadow [32];

	int tests_run = 0;
	int tests_failed = 0;
	int fails_at_start = 0;

	logic [5:0] legal_ops [12] = '{op_rtype, op_j, op_jal, op_beq, op_bne, op_addi, op_slti,
		op_andi, op_ori, op_lui, op_lw, op_sw};
	logic [5:0] imm_ops [10] = '{op_addi, op_slti, op_andi, op_ori, op_lw, op_sw, op_beq,
		op_bne, op_j, op_jal};
	logic [5:0] bad_ops [4] = '{6'h01, 6'h10, 6'h20, 6'h3f};
	logic [5:0] bad_functs [4] = '{6'h01, 6'h09, 6'h21, 6'h3f};

	id_stage i_id_stage (.*);

	bind id_stage id_stage_checker i_id_stage_checker (.*);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial
	begin
		#(total_cycles * 2 * clk_period);
		$display("watchdog expired before the tests completed");
		$display("TEST FAIL");
		$finish;
	end

	//////////////////////////////
	// Reference model

	function automatic logic [15:0] expected_controls(input logic [31:0] iw);
		alu_op_e op;
		logic [11:0] f;
		begin
			op = alu_nop;
			f  = '0;
			case (iw[31:26])
				op_rtype:
				begin
					case (iw[5:0])
						fn_add: op = alu_add;
						fn_sub: op = alu_sub;
						fn_and: op = alu_and;
						fn_or:  op = alu_or;
						fn_xor: op = alu_xor;
						fn_slt: op = alu_slt;
						fn_sll: op = alu_sll;
						fn_srl: op = alu_srl;
						fn_jr:  f[b_jump_reg] = 1'b1;
						default: f[b_illegal] = 1'b1;
					endcase
					// Every R-type ALU result goes to rd
					if (op != alu_nop)
					begin
						f[b_reg_dst]   = 1'b1;
						f[b_reg_write] = 1'b1;
					end
				end
				op_addi: op = alu_add;
				op_slti: op = alu_slt;
				op_andi: op = alu_and;
				op_ori:  op = alu_or;
				op_lui:  op = alu_lui;
				op_lw:
				begin
					op = alu_add;
					f[b_mem_read]   = 1'b1;
					f[b_mem_to_reg] = 1'b1;
				end
				op_sw:
				begin
					op = alu_add;
					f[b_mem_write] = 1'b1;
				end
				op_beq, op_bne:
				begin
					op = alu_sub;
					f[b_branch]    = 1'b1;
					f[b_branch_ne] = (iw[31:26] == op_bne);
				end
				op_j:    f[b_jump] = 1'b1;
				op_jal:
				begin
					f[b_jump]      = 1'b1;
					f[b_link]      = 1'b1;
					f[b_reg_write] = 1'b1;
				end
				default: f[b_illegal] = 1'b1;
			endcase
			if (iw[31:26] inside {op_addi, op_slti, op_andi, op_ori, op_lui, op_lw, op_sw})
				f[b_alu_src] = 1'b1;
			if (iw[31:26] inside {op_addi, op_slti, op_andi, op_ori, op_lui, op_lw})
				f[b_reg_write] = 1'b1;
			return {op, f};
		end
	endfunction

	// Register zero reads zero and a same-cycle write is seen at once
	function automatic logic [31:0] expected_read(input logic [4:0] addr, input logic we,
		input logic [4:0] wa, input logic [31:0] wd);
		begin
			if (addr == 5'd0)
				return 32'h0;
			if (we && wa == addr)
				return wd;
			return shadow[addr];
		end
	endfunction

	function automatic logic [31:0] rand_instr(input logic [5:0] op, input logic [5:0] fn);
		logic [31:0] iw;
		begin
			iw = $urandom;
			iw[31:26] = op;
			if (op == op_rtype)
				iw[5:0] = fn;
			return iw;
		end
	endfunction

	function automatic logic [31:0] rand_pc();
		return $urandom & 32'hffff_fffc;
	endfunction

	//////////////////////////////
	// Stimulus

	task automatic drive_cycle(input logic v, input logic [31:0] iw, input logic [31:0] pc,
		input logic we, input logic [4:0] wa, input logic [31:0] wd);
		logic [31:0] sext;
		begin
			sext = {{16{iw[15]}}, iw[15:0]};
			in_valid  = v;
			instr     = iw;
			pc_plus4  = pc;
			reg_write = we;
			wr_addr   = wa;
			wr_data   = wd;
			exp_ctrl          = expected_controls(iw);
			exp_rs_data       = expected_read(iw[25:21], we, wa, wd);
			exp_rt_data       = expected_read(iw[20:16], we, wa, wd);
			exp_imm_ext       = (iw[31:26] inside {op_andi, op_ori}) ? {16'h0, iw[15:0]} : sext;
			exp_branch_target = pc + (sext << 2);
			exp_jump_target   = {pc[31:28], iw[25:0], 2'b00};
			exp_pc_plus4      = pc;
			exp_rd_addr       = (iw[31:26] == op_jal) ? 5'd31 : iw[15:11];
			exp_rt_addr       = iw[20:16];
			exp_shamt         = iw[10:6];
			if (we && wa != 5'd0)
				shadow[wa] = wd;
			@(posedge clk);
			#2;
		end
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, $urandom, rand_pc(), 1'b0, 5'd0, 32'h0);
	endtask

	// One idle cycle lets the last instruction reach its checks
	task automatic close_test(input string name);
		int now_fails;
		begin
			idle_cycle();
			now_fails = i_id_stage.i_id_stage_checker.fail_count;
			tests_run++;
			if (now_fails == fails_at_start)
				$display("test %s: ok", name);
			else
			begin
				$display("test %s: %0d assertion failures", name, now_fails - fails_at_start);
				tests_failed++;
			end
			fails_at_start = now_fails;
		end
	endtask

	initial
	begin
		int i;
		int total_fails;
		logic [4:0] wa;
		logic [31:0] iw;
		opcode_e o;
		funct_e fn;

		void'($urandom(32'h22e5ec48));
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		instr     = 32'h0;
		pc_plus4  = 32'h0;
		reg_write = 1'b0;
		wr_addr   = 5'd0;
		wr_data   = 32'h0;
		for (i = 0; i < 32; i++)
			shadow[i] = 32'h0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// Valid and idle cycles mixed at random
		for (i = 0; i < n_idle; i++)
			drive_cycle(1'($urandom), rand_instr(legal_ops[$urandom_range(11, 0)], fn_add),
				rand_pc(), 1'b0, 5'd0, 32'h0);
		close_test("reset_and_bubbles");

		for (i = 0; i < n_regs; i++)
		begin
			wa = 5'($urandom);
			drive_cycle(1'b0, $urandom, rand_pc(), 1'b1, wa, $urandom);
			drive_cycle(1'b1, rand_instr(op_rtype, fn_add), rand_pc(), 1'b0, 5'd0, 32'h0);
		end
		// add r0, r0, r0 right after a write to r0
		drive_cycle(1'b0, 32'h0, rand_pc(), 1'b1, 5'd0, 32'hffff_ffff);
		drive_cycle(1'b1, 32'h0000_0020, rand_pc(), 1'b0, 5'd0, 32'h0);
		close_test("register_read");

		for (i = 0; i < n_wt; i++)
		begin
			wa = 5'($urandom_range(31, 1));
			iw = rand_instr(op_rtype, fn_or);
			if (i % 3 != 1)
				iw[25:21] = wa;
			if (i % 3 != 0)
				iw[20:16] = wa;
			drive_cycle(1'b1, iw, rand_pc(), 1'b1, wa, $urandom);
		end
		close_test("write_through");

		o = o.first();
		do
		begin
			drive_cycle(1'b1, rand_instr(o, fn_add), rand_pc(), 1'b0, 5'd0, 32'h0);
			o = o.next();
		end
		while (o != o.first());
		fn = fn.first();
		do
		begin
			drive_cycle(1'b1, rand_instr(op_rtype, fn), rand_pc(), 1'b0, 5'd0, 32'h0);
			fn = fn.next();
		end
		while (fn != fn.first());
		// Unknown opcodes and functs
		for (i = 0; i < 4; i++)
		begin
			drive_cycle(1'b1, rand_instr(bad_ops[i], fn_add), rand_pc(), 1'b0, 5'd0, 32'h0);
			drive_cycle(1'b1, rand_instr(op_rtype, bad_functs[i]), rand_pc(), 1'b0, 5'd0, 32'h0);
		end
		close_test("decode_table");

		for (i = 0; i < n_imm; i++)
			drive_cycle(1'b1, rand_instr(imm_ops[$urandom_range(9, 0)], fn_add), rand_pc(),
				1'b0, 5'd0, 32'h0);
		close_test("immediates_and_targets");

		total_fails = i_id_stage.i_id_stage_checker.fail_count;
		$display("tests run %0d, tests failed %0d, assertion failures %0d", tests_run,
			tests_failed, total_fails);
		if (tests_failed == 0 && total_fails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
isa_pkg.sv
ctrl_pkg.sv
control_unit.sv
register_file.sv
id_stage.sv
id_stage_checker.sv
tb_id_stage.sv
